/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exit status is zero only when the run reports a pass.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_pcie_app

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q -F "*** PASSED ***" <<< "$output"; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi

/* source/cfg_shadow.sv */
/*
 * Shadow copy of the config-space fields the application needs.
 * The hard IP cycles its address/data pair every clock; each field is
 * captured when its address comes round. Stage 2 re-registers the MSI
 * and device fields before they are packed onto the sideband buses.
 * Bus/device and master enable leave straight from stage 1.
 */
`timescale 1ns/100ps
`default_nettype none

module cfg_shadow
(
   input  wire                          AvlClk_i,
   input  wire                          rstn_reg,
   input  wire pcie_app_pkg::cfg_addr_e cfg_addr_i,
   input  wire pcie_app_pkg::cfg_word_t cfg_ctl_i,
   output pcie_app_pkg::msi_intfc_t     msi_intfc_o,
   output pcie_app_pkg::msix_ctrl_t     msix_intfc_o,
   output pcie_app_pkg::busdev_t        busdev_o,
   output pcie_app_pkg::cfg_word_t      dev_csr_o
);

   // Stage 1, loaded by address match
   pcie_app_pkg::busdev_t                      busdev;
   logic [pcie_app_pkg::CFG_W/2-1:0]           dev_csr;     // Upper half of config word
   logic                                       master_en;   // Command bit 2
   logic                                       msi_en;
   pcie_app_pkg::msix_ctrl_t                   msix_ctrl;
   logic [pcie_app_pkg::MSI_ADDR_W-1:0]        msi_addr;
   logic [pcie_app_pkg::MSI_DATA_W-1:0]        msi_data;

   // Stage 2
   logic [pcie_app_pkg::CFG_W/2-1:0]           dev_csr_q;
   logic                                       msi_en_q;
   pcie_app_pkg::msix_ctrl_t                   msix_ctrl_q;
   logic [pcie_app_pkg::MSI_ADDR_W-1:0]        msi_addr_q;
   logic [pcie_app_pkg::MSI_DATA_W-1:0]        msi_data_q;

   // Each field loads on its address match alone
   always_ff @(posedge AvlClk_i or negedge rstn_reg)
   begin
      if (!rstn_reg)
      begin
         busdev    <= '0;
         dev_csr   <= '0;
         master_en <= 1'b0;
         msi_en    <= 1'b0;
         msix_ctrl <= '0;
         msi_addr  <= '0;
         msi_data  <= '0;
      end
      else
      begin
         case (cfg_addr_i)
            pcie_app_pkg::CFG_DEVCSR        : dev_csr          <= cfg_ctl_i[31:16];
            pcie_app_pkg::CFG_PRMCSR        : master_en        <= cfg_ctl_i[10];
            pcie_app_pkg::CFG_MSI_ADDR_LO_A : msi_addr[11:0]   <= cfg_ctl_i[31:20];
            pcie_app_pkg::CFG_MSI_ADDR_LO_B : msi_addr[31:12]  <= cfg_ctl_i[31:12];
            pcie_app_pkg::CFG_MSI_ADDR_HI_A : msi_addr[43:32]  <= cfg_ctl_i[31:20];
            pcie_app_pkg::CFG_MSI_ADDR_HI_B : msi_addr[63:44]  <= cfg_ctl_i[31:12];
            pcie_app_pkg::CFG_MSI_CTRL :
            begin
               msi_en    <= cfg_ctl_i[0];       // Only the enable bit of the MSI control
               msix_ctrl <= cfg_ctl_i[31:16];
            end
            pcie_app_pkg::CFG_BUSDEV_MSIDATA :
            begin
               busdev    <= cfg_ctl_i[12:0];
               msi_data  <= cfg_ctl_i[31:16];
            end
            default : ;                         // Hold all fields
         endcase
      end
   end

   always_ff @(posedge AvlClk_i or negedge rstn_reg)
   begin
      if (!rstn_reg)
      begin
         dev_csr_q   <= '0;
         msi_en_q    <= 1'b0;
         msix_ctrl_q <= '0;
         msi_addr_q  <= '0;
         msi_data_q  <= '0;
      end
      else
      begin
         dev_csr_q   <= dev_csr;
         msi_en_q    <= msi_en;
         msix_ctrl_q <= msix_ctrl;
         msi_addr_q  <= msi_addr;
         msi_data_q  <= msi_data;
      end
   end

   // Sideband packing
   // Master enable leaves from stage 1
   assign msi_intfc_o  = {master_en, msi_en_q, msi_data_q, msi_addr_q};
   assign msix_intfc_o = msix_ctrl_q;
   assign busdev_o     = busdev;
   assign dev_csr_o    = {{(pcie_app_pkg::CFG_W/2){1'b0}}, dev_csr_q};

   // The hard IP drives the address every cycle once out of reset
   a_cfg_addr_known : assert property (
      @(posedge AvlClk_i) disable iff (!rstn_reg)
      !$isunknown(cfg_addr_i))
      else $error("cfg_shadow: config address unknown");

endmodule

`default_nettype wire

/* source/pcie_app_pkg.sv */
/*
 * Shared widths, BAR enable mask and types for the PCIe to Avalon
 * application glue (config shadow and read-return merge).
 * Modules refer to these by scoped name, so compile this package
 * ahead of every RTL file.
 */
`default_nettype none

package pcie_app_pkg;

   localparam int NUM_BARS    = 6;             // Rx master ports, one per BAR
   localparam int RD_DATA_W   = 128;           // Rx master read data
   localparam int CFG_W       = 32;            // Config word from the hard IP
   localparam int BUSDEV_W    = 13;
   localparam int MSI_ADDR_W  = 64;
   localparam int MSI_DATA_W  = 16;
   localparam int MSIX_CTRL_W = 16;

   // Address and data plus MSI enable and master enable on top
   localparam int MSI_INTFC_W = MSI_ADDR_W + MSI_DATA_W + 2;

   // One bit per BAR with a nonzero size
   // BAR0 to BAR2 are populated in this build
   localparam logic [NUM_BARS-1:0] BAR_ENABLED = 6'b000111;

   typedef logic [RD_DATA_W-1:0]   rd_data_t;
   typedef logic [NUM_BARS-1:0]    bar_vec_t;
   typedef logic [CFG_W-1:0]       cfg_word_t;
   typedef logic [BUSDEV_W-1:0]    busdev_t;
   typedef logic [MSI_INTFC_W-1:0] msi_intfc_t;
   typedef logic [MSIX_CTRL_W-1:0] msix_ctrl_t;

   // Config address from the hard IP
   // Values not named here carry nothing the application keeps
   typedef enum logic [3:0]
   {
      CFG_DEVCSR         = 4'h0,      // Device control/status
      CFG_PRMCSR         = 4'h3,      // Command register
      CFG_MSI_ADDR_LO_A  = 4'h5,      // MSI address [11:0]
      CFG_MSI_ADDR_HI_A  = 4'h6,      // MSI address [43:32]
      CFG_MSI_ADDR_LO_B  = 4'h9,      // MSI address [31:12]
      CFG_MSI_ADDR_HI_B  = 4'hB,      // MSI address [63:44]
      CFG_MSI_CTRL       = 4'hD,      // MSI enable and MSI-X control
      CFG_BUSDEV_MSIDATA = 4'hF       // Bus/device and MSI data
   } cfg_addr_e;

endpackage

`default_nettype wire

/* source/pcie_app_top.sv */
/*
 * Application-layer glue of the 128-bit PCIe to Avalon bridge.
 * Synchronizes the incoming reset and hosts the config-space shadow
 * and the BAR read-return merge. All logic runs on AvlClk_i.
 */
`timescale 1ns/100ps
`default_nettype none

module pcie_app_top
(
   input  wire                          AvlClk_i,
   input  wire                          Rstn_i,          // Async, active low

   // Config bus from the hard IP
   input  wire pcie_app_pkg::cfg_addr_e cfg_addr_i,
   input  wire pcie_app_pkg::cfg_word_t cfg_ctl_i,

   // BAR master read returns
   input  wire pcie_app_pkg::bar_vec_t  rxm_rd_valid_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_0_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_1_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_2_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_3_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_4_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_5_i,

   output pcie_app_pkg::msi_intfc_t     msi_intfc_o,
   output pcie_app_pkg::msix_ctrl_t     msix_intfc_o,
   output pcie_app_pkg::busdev_t        busdev_o,
   output pcie_app_pkg::cfg_word_t      dev_csr_o,
   output logic                         cpl_valid_o,
   output pcie_app_pkg::rd_data_t       cpl_data_o
);

   logic rstn_meta;
   logic rstn_reg;     // Synchronized reset for all other logic

   // Assert asynchronously, release on the second edge after Rstn_i rises
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         rstn_meta <= 1'b0;
         rstn_reg  <= 1'b0;
      end
      else
      begin
         rstn_meta <= 1'b1;
         rstn_reg  <= rstn_meta;
      end
   end

   cfg_shadow cfg_shadow0
   (
      .AvlClk_i     (AvlClk_i),
      .rstn_reg     (rstn_reg),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_ctl_i    (cfg_ctl_i),
      .msi_intfc_o  (msi_intfc_o),
      .msix_intfc_o (msix_intfc_o),
      .busdev_o     (busdev_o),
      .dev_csr_o    (dev_csr_o)
   );

   rd_return_mux rd_return_mux0
   (
      .AvlClk_i        (AvlClk_i),
      .rstn_reg        (rstn_reg),
      .rxm_rd_valid_i  (rxm_rd_valid_i),
      .rxm_rd_data_0_i (rxm_rd_data_0_i),
      .rxm_rd_data_1_i (rxm_rd_data_1_i),
      .rxm_rd_data_2_i (rxm_rd_data_2_i),
      .rxm_rd_data_3_i (rxm_rd_data_3_i),
      .rxm_rd_data_4_i (rxm_rd_data_4_i),
      .rxm_rd_data_5_i (rxm_rd_data_5_i),
      .cpl_valid_o     (cpl_valid_o),
      .cpl_data_o      (cpl_data_o)
   );

endmodule

`default_nettype wire

/* source/rd_return_mux.sv */
/*
 * Merges the six BAR master read-data returns into the single completion
 * data path. Purely combinational, no back-pressure.
 * A BAR without a size never reaches the output. Exactly one valid
 * selects that BAR's data; several valids at once give valid with
 * zero data. Clock and reset are only used to sample the assertion.
 */
`timescale 1ns/100ps
`default_nettype none

module rd_return_mux
(
   input  wire                          AvlClk_i,
   input  wire                          rstn_reg,
   input  wire pcie_app_pkg::bar_vec_t  rxm_rd_valid_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_0_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_1_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_2_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_3_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_4_i,
   input  wire pcie_app_pkg::rd_data_t  rxm_rd_data_5_i,
   output logic                         cpl_valid_o,
   output pcie_app_pkg::rd_data_t       cpl_data_o
);

   pcie_app_pkg::bar_vec_t rd_valid_eff;   // Valid after BAR enable gating

   // Unpopulated BARs are silenced here
   assign rd_valid_eff = rxm_rd_valid_i & pcie_app_pkg::BAR_ENABLED;

   assign cpl_valid_o  = |rd_valid_eff;

   always_comb
   begin
      case (rd_valid_eff)
         6'b000001 : cpl_data_o = rxm_rd_data_0_i;
         6'b000010 : cpl_data_o = rxm_rd_data_1_i;
         6'b000100 : cpl_data_o = rxm_rd_data_2_i;
         6'b001000 : cpl_data_o = rxm_rd_data_3_i;
         6'b010000 : cpl_data_o = rxm_rd_data_4_i;
         6'b100000 : cpl_data_o = rxm_rd_data_5_i;
         default   : cpl_data_o = '0;   // Idle or collision
      endcase
   end

   // Completion data stays quiet between returns
   a_idle_data_zero : assert property (
      @(posedge AvlClk_i) disable iff (!rstn_reg)
      !cpl_valid_o |-> (cpl_data_o == '0))
      else $error("rd_return_mux: data present without valid");

endmodule

`default_nettype wire

/* verification/tb_pcie_app.sv */
/*
 * Directed testbench for the PCIe application glue.
 * Drives the config address/data pair and the BAR read returns on the
 * falling clock edge and checks against a model of the config fields.
 * Run through vlog.f with tb_pcie_app as the top module.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_app;

   localparam int CLK_PERIOD      = 8;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam logic [3:0] UNUSED_ADDRS [8] = '{4'h1, 4'h2, 4'h4, 4'h7, 4'h8, 4'hA, 4'hC, 4'hE};
   localparam logic [5:0] POPULATED_BARS = 6'b000111;   // BAR0 to BAR2 have a size

   logic                      avl_clk;
   logic                      rstn;
   pcie_app_pkg::cfg_addr_e   cfg_addr;
   pcie_app_pkg::cfg_word_t   cfg_ctl;
   pcie_app_pkg::bar_vec_t    rd_valid;
   pcie_app_pkg::rd_data_t    rd_data [pcie_app_pkg::NUM_BARS];
   pcie_app_pkg::msi_intfc_t  msi_intfc;
   pcie_app_pkg::msix_ctrl_t  msix_intfc;
   pcie_app_pkg::busdev_t     busdev;
   pcie_app_pkg::cfg_word_t   dev_csr;
   logic                      cpl_valid;
   pcie_app_pkg::rd_data_t    cpl_data;

   // Model of the captured config fields
   logic [63:0]               m_msi_addr;
   logic [15:0]               m_msi_data;
   logic                      m_msi_en;
   logic                      m_master_en;
   logic [15:0]               m_msix;
   logic [12:0]               m_busdev;
   logic [15:0]               m_dev_csr;

   int                        errors;
   int                        checks;

   pcie_app_top dut0
   (
      .AvlClk_i        (avl_clk),
      .Rstn_i          (rstn),
      .cfg_addr_i      (cfg_addr),
      .cfg_ctl_i       (cfg_ctl),
      .rxm_rd_valid_i  (rd_valid),
      .rxm_rd_data_0_i (rd_data[0]),
      .rxm_rd_data_1_i (rd_data[1]),
      .rxm_rd_data_2_i (rd_data[2]),
      .rxm_rd_data_3_i (rd_data[3]),
      .rxm_rd_data_4_i (rd_data[4]),
      .rxm_rd_data_5_i (rd_data[5]),
      .msi_intfc_o     (msi_intfc),
      .msix_intfc_o    (msix_intfc),
      .busdev_o        (busdev),
      .dev_csr_o       (dev_csr),
      .cpl_valid_o     (cpl_valid),
      .cpl_data_o      (cpl_data)
   );

   initial
   begin
      avl_clk = 1'b0;
      forever #(CLK_PERIOD/2) avl_clk = ~avl_clk;
   end

   // Limit of the whole run
   initial
   begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired, the tests did not complete in time");
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check_msi(input string name, input pcie_app_pkg::msi_intfc_t exp,
                            input pcie_app_pkg::msi_intfc_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_msix(input string name, input pcie_app_pkg::msix_ctrl_t exp,
                             input pcie_app_pkg::msix_ctrl_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_busdev(input string name, input pcie_app_pkg::busdev_t exp,
                               input pcie_app_pkg::busdev_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input pcie_app_pkg::cfg_word_t exp,
                             input pcie_app_pkg::cfg_word_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input pcie_app_pkg::rd_data_t exp,
                             input pcie_app_pkg::rd_data_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // MSI sideband as seen once all captures have settled
   function automatic pcie_app_pkg::msi_intfc_t expected_msi();
      return {m_master_en, m_msi_en, m_msi_data, m_msi_addr};
   endfunction

   // Drives one address/data pair and updates the model
   task automatic cfg_write(input pcie_app_pkg::cfg_addr_e addr,
                            input pcie_app_pkg::cfg_word_t word);
      @(negedge avl_clk);
      cfg_addr = addr;
      cfg_ctl  = word;
      case (addr)
         pcie_app_pkg::CFG_DEVCSR         : m_dev_csr         = word[31:16];
         pcie_app_pkg::CFG_PRMCSR         : m_master_en       = word[10];
         pcie_app_pkg::CFG_MSI_ADDR_LO_A  : m_msi_addr[11:0]  = word[31:20];
         pcie_app_pkg::CFG_MSI_ADDR_LO_B  : m_msi_addr[31:12] = word[31:12];
         pcie_app_pkg::CFG_MSI_ADDR_HI_A  : m_msi_addr[43:32] = word[31:20];
         pcie_app_pkg::CFG_MSI_ADDR_HI_B  : m_msi_addr[63:44] = word[31:12];
         pcie_app_pkg::CFG_MSI_CTRL :
         begin
            m_msi_en = word[0];
            m_msix   = word[31:16];
         end
         pcie_app_pkg::CFG_BUSDEV_MSIDATA :
         begin
            m_busdev   = word[12:0];
            m_msi_data = word[31:16];
         end
         default : ;
      endcase
   endtask

   // Parks the address at an unused value after the last capture
   task automatic park_cfg();
      @(negedge avl_clk);
      cfg_addr = pcie_app_pkg::cfg_addr_e'(4'h1);
      cfg_ctl  = $urandom;
   endtask

   task automatic test_reset_state();
      check_msi("reset", '0, msi_intfc);
      check_msix("reset", '0, msix_intfc);
      check_busdev("reset", '0, busdev);
      check_word("reset", '0, dev_csr);
      check_valid("reset", 1'b0, cpl_valid);
      check_data("reset", '0, cpl_data);
   endtask

   task automatic test_msi_address();
      pcie_app_pkg::cfg_word_t w5;
      pcie_app_pkg::cfg_word_t w9;
      pcie_app_pkg::cfg_word_t w6;
      pcie_app_pkg::cfg_word_t w11;
      logic [63:0]             exp_addr;
      w5  = $urandom;
      w9  = $urandom;
      w6  = $urandom;
      w11 = $urandom;
      exp_addr = {w11[31:12], w6[31:20], w9[31:12], w5[31:20]};
      cfg_write(pcie_app_pkg::CFG_MSI_ADDR_LO_A, w5);
      cfg_write(pcie_app_pkg::CFG_MSI_ADDR_LO_B, w9);
      cfg_write(pcie_app_pkg::CFG_MSI_ADDR_HI_A, w6);
      cfg_write(pcie_app_pkg::CFG_MSI_ADDR_HI_B, w11);
      park_cfg();
      @(negedge avl_clk);
      check_msi("msi_address", {m_master_en, m_msi_en, m_msi_data, exp_addr}, msi_intfc);
   endtask

   task automatic test_shared_fields();
      pcie_app_pkg::msi_intfc_t old_msi;
      cfg_write(pcie_app_pkg::CFG_MSI_CTRL, $urandom | 32'h1);   // MSI enabled
      park_cfg();
      @(negedge avl_clk);
      check_msi("msi_ctrl", expected_msi(), msi_intfc);
      check_msix("msi_ctrl", m_msix, msix_intfc);
      old_msi = expected_msi();
      cfg_write(pcie_app_pkg::CFG_BUSDEV_MSIDATA, $urandom);
      park_cfg();
      check_busdev("busdev_1cyc", m_busdev, busdev);
      check_msi("msi_data_1cyc", old_msi, msi_intfc);           // Data not yet through stage 2
      @(negedge avl_clk);
      check_msi("msi_data_2cyc", expected_msi(), msi_intfc);
      cfg_write(pcie_app_pkg::CFG_DEVCSR, $urandom);
      park_cfg();
      @(negedge avl_clk);
      check_word("dev_csr", {16'h0, m_dev_csr}, dev_csr);
   endtask

   task automatic test_master_enable();
      cfg_write(pcie_app_pkg::CFG_PRMCSR, $urandom | 32'h400);
      park_cfg();
      check_msi("master_en_1cyc", expected_msi(), msi_intfc);
      for (int i = 0; i < 8; i++)
         cfg_write(pcie_app_pkg::cfg_addr_e'(UNUSED_ADDRS[i]), $urandom);
      park_cfg();
      @(negedge avl_clk);
      check_msi("unused_addr", expected_msi(), msi_intfc);
      check_msix("unused_addr", m_msix, msix_intfc);
      check_busdev("unused_addr", m_busdev, busdev);
      check_word("unused_addr", {16'h0, m_dev_csr}, dev_csr);
   endtask

   task automatic load_random_data();
      for (int b = 0; b < pcie_app_pkg::NUM_BARS; b++)
         rd_data[b] = {$urandom, $urandom, $urandom, $urandom};
   endtask

   task automatic test_read_per_bar();
      logic en;
      for (int b = 0; b < pcie_app_pkg::NUM_BARS; b++)
      begin
         en = POPULATED_BARS[b];
         @(negedge avl_clk);
         load_random_data();
         rd_valid = 6'b000001 << b;
         @(posedge avl_clk);
         check_valid($sformatf("bar%0d_valid", b), en, cpl_valid);
         check_data($sformatf("bar%0d_data", b), en ? rd_data[b] : '0, cpl_data);
         @(negedge avl_clk);
         rd_valid = '0;
      end
   endtask

   task automatic test_multiple_valids();
      @(negedge avl_clk);
      load_random_data();
      rd_valid = 6'b000101;                  // BAR0 and BAR2 together
      @(posedge avl_clk);
      check_valid("two_enabled", 1'b1, cpl_valid);
      check_data("two_enabled", '0, cpl_data);
      @(negedge avl_clk);
      rd_valid = 6'b010010;                  // BAR1 with unpopulated BAR4
      @(posedge avl_clk);
      check_valid("enabled_disabled", 1'b1, cpl_valid);
      check_data("enabled_disabled", rd_data[1], cpl_data);
      @(negedge avl_clk);
      rd_valid = '0;
   endtask

   initial
   begin
      void'($urandom(32'h87ec));
      errors      = 0;
      checks      = 0;
      rstn        = 1'b0;
      cfg_addr    = pcie_app_pkg::cfg_addr_e'(4'h1);
      cfg_ctl     = '0;
      rd_valid    = '0;
      for (int b = 0; b < pcie_app_pkg::NUM_BARS; b++)
         rd_data[b] = '0;
      m_msi_addr  = '0;
      m_msi_data  = '0;
      m_msi_en    = 1'b0;
      m_master_en = 1'b0;
      m_msix      = '0;
      m_busdev    = '0;
      m_dev_csr   = '0;
      repeat (5) @(negedge avl_clk);
      rstn = 1'b1;
      repeat (3) @(negedge avl_clk);       // Synchronizer release
      test_reset_state();
      test_msi_address();
      test_shared_fields();
      test_master_enable();
      test_read_per_bar();
      test_multiple_valids();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
source/pcie_app_pkg.sv
source/cfg_shadow.sv
source/rd_return_mux.sv
source/pcie_app_top.sv
verification/tb_pcie_app.sv
